//--- verilog/udp_echo_pkg.sv
package udp_echo_pkg;

    localparam int DATA_W     = 32;
    localparam int IP_W       = 32;
    localparam int PORT_W     = 16;
    localparam int HDR_WORDS  = 3;
    localparam int NUM_PORTS  = 3;
    localparam int SLOT_IDX_W = 2;

    localparam logic [IP_W-1:0] LOCAL_IP = 32'h0A00_0001;

    // slot 0 sits in the low bits
    localparam logic [NUM_PORTS*PORT_W-1:0] PORT_TABLE = {16'd60001, 16'd60000, 16'd65432};

    typedef struct packed {
        logic [IP_W-1:0]    src_ip;
        logic [IP_W-1:0]    dst_ip;
        logic [PORT_W-1:0]  src_port;
        logic [PORT_W-1:0]  dst_port;
    } udp_hdr_t;

    typedef struct packed {
        logic [DATA_W-1:0]  data;
        logic               last;
    } data_beat_t;

    typedef struct packed {
        logic [PORT_W-1:0]  src_port;
        logic [PORT_W-1:0]  dst_port;
    } port_pair_t;

    // header word 2 carries both ports
    typedef union packed {
        logic [DATA_W-1:0]  raw;
        port_pair_t         ports;
    } rx_word_u;

endpackage

//--- verilog/udp_rx_parser.sv
`timescale 1ns/100ps
module udp_rx_parser (
     input  logic                               clk
    ,input  logic                               rst_n

    ,input  logic                               rx_val
    ,input  logic [udp_echo_pkg::DATA_W-1:0]    rx_data
    ,input  logic                               rx_last
    ,output logic                               rx_rdy

    ,output logic                               hdr_val
    ,output udp_echo_pkg::udp_hdr_t             hdr
    ,input  logic                               hdr_rdy

    ,output logic                               data_val
    ,output udp_echo_pkg::data_beat_t           beat
    ,input  logic                               data_rdy
);
    import udp_echo_pkg::*;

    rx_word_u   word;
    logic [1:0] cnt;        // header word index
    logic       collecting;
    logic       pay;
    logic       drop;       // swallows the rest of a filtered frame

    assign word = rx_data;
    assign collecting = ~hdr_val & ~pay & ~drop;

    assign rx_rdy = collecting | drop | (pay & data_rdy);
    assign data_val = pay & rx_val;
    assign beat = '{data: word.raw, last: rx_last};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            hdr_val <= 1'b0;
            pay <= 1'b0;
            drop <= 1'b0;
        end else begin
            if (collecting && rx_val) begin
                if (cnt == 2'(HDR_WORDS - 1)) begin
                    cnt <= '0;
                    if (hdr.dst_ip == LOCAL_IP) hdr_val <= 1'b1;
                    else drop <= 1'b1;
                end else begin
                    cnt <= cnt + 2'd1;
                end
            end
            if (hdr_val && hdr_rdy) begin
                hdr_val <= 1'b0;
                pay <= 1'b1;
            end
            if ((pay || drop) && rx_val && rx_rdy && rx_last) begin
                pay <= 1'b0;
                drop <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (collecting && rx_val) begin
            case (cnt)
                2'd0: hdr.src_ip <= word.raw;
                2'd1: hdr.dst_ip <= word.raw;
                default: begin
                    hdr.src_port <= word.ports.src_port;
                    hdr.dst_port <= word.ports.dst_port;
                end
            endcase
        end
    end

    // frames carry at least one payload word after the header
    assert property (@(posedge clk) disable iff (!rst_n) (collecting && rx_val) |-> !rx_last);

endmodule

//--- verilog/udp_port_splitter.sv
`timescale 1ns/100ps
module udp_port_splitter (
     input  logic                                   clk
    ,input  logic                                   rst_n

    ,input  logic                                   in_hdr_val
    ,input  udp_echo_pkg::udp_hdr_t                 in_hdr
    ,output logic                                   in_hdr_rdy

    ,input  logic                                   in_data_val
    ,input  udp_echo_pkg::data_beat_t               in_beat
    ,output logic                                   in_data_rdy

    ,output logic [udp_echo_pkg::NUM_PORTS-1:0]     out_hdr_val
    ,output udp_echo_pkg::udp_hdr_t                 out_hdr
    ,input  logic [udp_echo_pkg::NUM_PORTS-1:0]     out_hdr_rdy

    ,output logic [udp_echo_pkg::NUM_PORTS-1:0]     out_data_val
    ,output udp_echo_pkg::data_beat_t               out_beat
    ,input  logic [udp_echo_pkg::NUM_PORTS-1:0]     out_data_rdy
);
    import udp_echo_pkg::*;

    logic [NUM_PORTS-1:0]   match;
    logic [NUM_PORTS-1:0]   slot_oh;    // target of the current frame
    logic                   busy;
    logic                   drop;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            match[i] = in_hdr.dst_port == PORT_TABLE[i*PORT_W +: PORT_W];
        end
    end

    assign out_hdr = in_hdr;
    assign out_hdr_val = {NUM_PORTS{in_hdr_val & ~busy}} & match;
    // no match means the header is eaten here
    assign in_hdr_rdy = ~busy & (~|match | |(match & out_hdr_rdy));

    assign drop = ~|slot_oh;
    assign out_beat = in_beat;
    assign out_data_val = {NUM_PORTS{in_data_val & busy}} & slot_oh;
    assign in_data_rdy = busy & (drop | |(slot_oh & out_data_rdy));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            slot_oh <= '0;
        end else if (in_hdr_val && in_hdr_rdy) begin
            busy <= 1'b1;
            slot_oh <= match;
        end else if (in_data_val && in_data_rdy && in_beat.last) begin
            busy <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(out_hdr_val));

endmodule

//--- verilog/udp_echo_slot.sv
`timescale 1ns/100ps
module udp_echo_slot (
     input  logic                       clk
    ,input  logic                       rst_n

    ,input  logic                       in_hdr_val
    ,input  udp_echo_pkg::udp_hdr_t     in_hdr
    ,output logic                       in_hdr_rdy

    ,input  logic                       in_data_val
    ,input  udp_echo_pkg::data_beat_t   in_beat
    ,output logic                       in_data_rdy

    ,output logic                       out_hdr_val
    ,output udp_echo_pkg::udp_hdr_t     out_hdr
    ,input  logic                       out_hdr_rdy

    ,output logic                       out_data_val
    ,output udp_echo_pkg::data_beat_t   out_beat
    ,input  logic                       out_data_rdy
);
    import udp_echo_pkg::*;

    logic busy;     // set from header until last beat leaves

    assign in_hdr_rdy = ~busy;
    assign in_data_rdy = busy & (~out_data_val | out_data_rdy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            out_hdr_val <= 1'b0;
            out_data_val <= 1'b0;
        end else begin
            if (in_hdr_val && in_hdr_rdy) begin
                busy <= 1'b1;
                out_hdr_val <= 1'b1;
            end else if (out_hdr_val && out_hdr_rdy) begin
                out_hdr_val <= 1'b0;
            end
            if (in_data_val && in_data_rdy) out_data_val <= 1'b1;
            else if (out_data_rdy) out_data_val <= 1'b0;
            if (out_data_val && out_data_rdy && out_beat.last) busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_hdr_val && in_hdr_rdy) begin
            out_hdr <= '{src_ip:   in_hdr.dst_ip,
                         dst_ip:   in_hdr.src_ip,
                         src_port: in_hdr.dst_port,
                         dst_port: in_hdr.src_port};
        end
        if (in_data_val && in_data_rdy) out_beat <= in_beat;
    end

endmodule

//--- verilog/udp_tx_merger.sv
`timescale 1ns/100ps
module udp_tx_merger (
     input  logic                                                   clk
    ,input  logic                                                   rst_n

    ,input  logic [udp_echo_pkg::NUM_PORTS-1:0]                     in_hdr_val
    ,input  udp_echo_pkg::udp_hdr_t [udp_echo_pkg::NUM_PORTS-1:0]   in_hdr
    ,output logic [udp_echo_pkg::NUM_PORTS-1:0]                     in_hdr_rdy

    ,input  logic [udp_echo_pkg::NUM_PORTS-1:0]                     in_data_val
    ,input  udp_echo_pkg::data_beat_t [udp_echo_pkg::NUM_PORTS-1:0] in_beat
    ,output logic [udp_echo_pkg::NUM_PORTS-1:0]                     in_data_rdy

    ,output logic                                                   out_hdr_val
    ,output udp_echo_pkg::udp_hdr_t                                 out_hdr
    ,input  logic                                                   out_hdr_rdy

    ,output logic                                                   out_data_val
    ,output udp_echo_pkg::data_beat_t                               out_beat
    ,input  logic                                                   out_data_rdy
);
    import udp_echo_pkg::*;

    logic [SLOT_IDX_W-1:0]  sel;    // granted slot and rr pointer
    logic [SLOT_IDX_W-1:0]  pick;
    logic [SLOT_IDX_W-1:0]  cand;
    logic                   found;
    logic                   hdr_phase;
    logic                   data_phase;
    logic [NUM_PORTS-1:0]   gnt;

    // search starts one past the last served slot
    always_comb begin
        found = 1'b0;
        pick = sel;
        cand = sel;
        for (int k = NUM_PORTS; k >= 1; k--) begin
            cand = SLOT_IDX_W'((sel + k) % NUM_PORTS);
            if (in_hdr_val[cand]) begin
                found = 1'b1;
                pick = cand;
            end
        end
    end

    assign gnt = (hdr_phase | data_phase) ? ({{(NUM_PORTS-1){1'b0}}, 1'b1} << sel) : '0;

    assign out_hdr_val = hdr_phase & in_hdr_val[sel];
    assign out_hdr = in_hdr[sel];
    assign in_hdr_rdy = {NUM_PORTS{hdr_phase & out_hdr_rdy}} & gnt;

    assign out_data_val = data_phase & in_data_val[sel];
    assign out_beat = in_beat[sel];
    assign in_data_rdy = {NUM_PORTS{data_phase & out_data_rdy}} & gnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel <= '0;
            hdr_phase <= 1'b0;
            data_phase <= 1'b0;
        end else begin
            if (!hdr_phase && !data_phase && found) begin
                hdr_phase <= 1'b1;
                sel <= pick;
            end
            if (out_hdr_val && out_hdr_rdy) begin
                hdr_phase <= 1'b0;
                data_phase <= 1'b1;
            end
            if (out_data_val && out_data_rdy && out_beat.last) data_phase <= 1'b0;
        end
    end

    // locked slot holds its header until taken and offers no new one mid-frame
    assert property (@(posedge clk) disable iff (!rst_n)
        (hdr_phase || data_phase) |-> (in_hdr_val[sel] == hdr_phase));

endmodule

//--- verilog/udp_tx_serializer.sv
`timescale 1ns/100ps
module udp_tx_serializer (
     input  logic                               clk
    ,input  logic                               rst_n

    ,input  logic                               hdr_val
    ,input  udp_echo_pkg::udp_hdr_t             hdr
    ,output logic                               hdr_rdy

    ,input  logic                               data_val
    ,input  udp_echo_pkg::data_beat_t           beat
    ,output logic                               data_rdy

    ,output logic                               tx_val
    ,output logic [udp_echo_pkg::DATA_W-1:0]    tx_data
    ,output logic                               tx_last
    ,input  logic                               tx_rdy
);
    import udp_echo_pkg::*;

    udp_hdr_t   hdr_q;
    logic [1:0] cnt;
    logic       hdr_phase;
    logic       pay_phase;

    assign hdr_rdy = ~hdr_phase & ~pay_phase;
    assign data_rdy = pay_phase & tx_rdy;
    assign tx_val = hdr_phase | (pay_phase & data_val);
    assign tx_last = pay_phase & beat.last;

    always_comb begin
        if (pay_phase) begin
            tx_data = beat.data;
        end else begin
            case (cnt)
                2'd0: tx_data = hdr_q.src_ip;
                2'd1: tx_data = hdr_q.dst_ip;
                default: tx_data = {hdr_q.src_port, hdr_q.dst_port};
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            hdr_phase <= 1'b0;
            pay_phase <= 1'b0;
        end else begin
            if (hdr_val && hdr_rdy) begin
                hdr_phase <= 1'b1;
                cnt <= '0;
            end
            if (hdr_phase && tx_rdy) begin
                if (cnt == 2'(HDR_WORDS - 1)) begin
                    hdr_phase <= 1'b0;
                    pay_phase <= 1'b1;
                end else begin
                    cnt <= cnt + 2'd1;
                end
            end
            if (pay_phase && data_val && tx_rdy && beat.last) pay_phase <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_val && hdr_rdy) hdr_q <= hdr;
    end

    // payload words hold only if the slot registers hold them
    assert property (@(posedge clk) disable iff (!rst_n)
        (tx_val && !tx_rdy) |=> (tx_val && $stable(tx_data) && $stable(tx_last)));

endmodule

//--- verilog/udp_echo_top.sv
`timescale 1ns/100ps
module udp_echo_top (
     input  logic                               clk
    ,input  logic                               rst_n

    ,input  logic                               rx_val
    ,input  logic [udp_echo_pkg::DATA_W-1:0]    rx_data
    ,input  logic                               rx_last
    ,output logic                               rx_rdy

    ,output logic                               tx_val
    ,output logic [udp_echo_pkg::DATA_W-1:0]    tx_data
    ,output logic                               tx_last
    ,input  logic                               tx_rdy
);
    import udp_echo_pkg::*;

    logic                               prs_hdr_val, prs_hdr_rdy;
    udp_hdr_t                           prs_hdr;
    logic                               prs_data_val, prs_data_rdy;
    data_beat_t                         prs_beat;

    logic [NUM_PORTS-1:0]               spl_hdr_val, spl_hdr_rdy;
    udp_hdr_t                           spl_hdr;
    logic [NUM_PORTS-1:0]               spl_data_val, spl_data_rdy;
    data_beat_t                         spl_beat;

    logic [NUM_PORTS-1:0]               slot_hdr_val, slot_hdr_rdy;
    udp_hdr_t [NUM_PORTS-1:0]           slot_hdr;
    logic [NUM_PORTS-1:0]               slot_data_val, slot_data_rdy;
    data_beat_t [NUM_PORTS-1:0]         slot_beat;

    logic                               mrg_hdr_val, mrg_hdr_rdy;
    udp_hdr_t                           mrg_hdr;
    logic                               mrg_data_val, mrg_data_rdy;
    data_beat_t                         mrg_beat;

    udp_rx_parser rx_parser (
         .clk (clk), .rst_n (rst_n)
        ,.rx_val (rx_val), .rx_data (rx_data), .rx_last (rx_last), .rx_rdy (rx_rdy)
        ,.hdr_val (prs_hdr_val), .hdr (prs_hdr), .hdr_rdy (prs_hdr_rdy)
        ,.data_val (prs_data_val), .beat (prs_beat), .data_rdy (prs_data_rdy)
    );

    udp_port_splitter rx_splitter (
         .clk (clk), .rst_n (rst_n)
        ,.in_hdr_val (prs_hdr_val), .in_hdr (prs_hdr), .in_hdr_rdy (prs_hdr_rdy)
        ,.in_data_val (prs_data_val), .in_beat (prs_beat), .in_data_rdy (prs_data_rdy)
        ,.out_hdr_val (spl_hdr_val), .out_hdr (spl_hdr), .out_hdr_rdy (spl_hdr_rdy)
        ,.out_data_val (spl_data_val), .out_beat (spl_beat), .out_data_rdy (spl_data_rdy)
    );

    for (genvar i = 0; i < NUM_PORTS; i++) begin : slot_gen
        udp_echo_slot echo_slot (
             .clk (clk), .rst_n (rst_n)
            ,.in_hdr_val (spl_hdr_val[i]), .in_hdr (spl_hdr), .in_hdr_rdy (spl_hdr_rdy[i])
            ,.in_data_val (spl_data_val[i]), .in_beat (spl_beat)
            ,.in_data_rdy (spl_data_rdy[i])
            ,.out_hdr_val (slot_hdr_val[i]), .out_hdr (slot_hdr[i])
            ,.out_hdr_rdy (slot_hdr_rdy[i])
            ,.out_data_val (slot_data_val[i]), .out_beat (slot_beat[i])
            ,.out_data_rdy (slot_data_rdy[i])
        );
    end

    udp_tx_merger tx_merger (
         .clk (clk), .rst_n (rst_n)
        ,.in_hdr_val (slot_hdr_val), .in_hdr (slot_hdr), .in_hdr_rdy (slot_hdr_rdy)
        ,.in_data_val (slot_data_val), .in_beat (slot_beat), .in_data_rdy (slot_data_rdy)
        ,.out_hdr_val (mrg_hdr_val), .out_hdr (mrg_hdr), .out_hdr_rdy (mrg_hdr_rdy)
        ,.out_data_val (mrg_data_val), .out_beat (mrg_beat), .out_data_rdy (mrg_data_rdy)
    );

    udp_tx_serializer tx_serializer (
         .clk (clk), .rst_n (rst_n)
        ,.hdr_val (mrg_hdr_val), .hdr (mrg_hdr), .hdr_rdy (mrg_hdr_rdy)
        ,.data_val (mrg_data_val), .beat (mrg_beat), .data_rdy (mrg_data_rdy)
        ,.tx_val (tx_val), .tx_data (tx_data), .tx_last (tx_last), .tx_rdy (tx_rdy)
    );

endmodule

//--- dv/udp_echo_tasks.svh
task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic report_failure(input string msg);
    errors++;
    $display("%s at %0t", msg, $time);
endtask

function automatic int slot_of_port(input logic [15:0] port);
    slot_of_port = -1;
    for (int i = 0; i < NUM_PORTS; i++) begin
        if (slot_ports[i] == port) slot_of_port = i;
    end
endfunction

function automatic int pending_words();
    pending_words = 0;
    for (int i = 0; i < NUM_PORTS; i++) pending_words += exp_q[i].size();
endfunction

// matches one complete reply to its slot by the reply src port
task automatic take_reply();
    logic [32:0] w;
    int slot;
    if (cur.size() < HDR_WORDS + 1) begin
        report_failure("reply shorter than header plus one payload word");
    end else begin
        w = cur[2];
        slot = slot_of_port(w[31:16]);
        if (slot < 0) report_failure("reply from a port outside the port table");
        else if (exp_q[slot].size() < cur.size()) report_failure("unexpected reply on tx");
        else begin
            foreach (cur[i]) begin
                w = exp_q[slot].pop_front();
                check_value("{tx_last,tx_data}", cur[i], w);
            end
        end
    end
    cur.delete();
endtask

task automatic drive_word(input logic [31:0] data, input logic last);
    logic taken;
    rx_val = 1'b1;
    rx_data = data;
    rx_last = last;
    do begin
        @(negedge clk);
        taken = rx_rdy;
        if (!taken) rx_stall_cnt++;
        @(posedge clk);
    end while (!taken);
    #1;
endtask

task automatic send_frame(input logic [31:0] sip, input logic [31:0] dip,
                          input logic [15:0] sport, input logic [15:0] dport, input int len);
    logic [31:0] pay [$];
    int slot;
    for (int i = 0; i < len; i++) pay.push_back($random(seed));
    slot = slot_of_port(dport);
    if (dip == OWN_IP && slot >= 0) begin   // reply has ips and ports swapped
        exp_q[slot].push_back({1'b0, dip});
        exp_q[slot].push_back({1'b0, sip});
        exp_q[slot].push_back({1'b0, dport, sport});
        foreach (pay[i]) exp_q[slot].push_back({i == len - 1, pay[i]});
    end
    drive_word(sip, 1'b0);
    drive_word(dip, 1'b0);
    drive_word({sport, dport}, 1'b0);
    foreach (pay[i]) drive_word(pay[i], i == len - 1);
    rx_val = 1'b0;
    rx_last = 1'b0;
endtask

task automatic wait_replies();
    while (pending_words() != 0) @(posedge clk);
    @(posedge clk);
    #1;
endtask

task automatic expect_quiet(input int n);
    repeat (n) begin
        @(negedge clk);
        check_value("tx_val", tx_val, 1'b0);
    end
    @(posedge clk);
    #1;
endtask

task automatic test_idle_after_reset();
    expect_quiet(20);
endtask

task automatic test_single_echo();
    send_frame(32'hC0A8_0105, OWN_IP, 16'd5001, 16'd65432, 4);
    wait_replies();
endtask

task automatic test_ip_filter();
    send_frame(32'hC0A8_0106, 32'h0A00_0002, 16'd5002, 16'd65432, 3);
    send_frame(32'hC0A8_0107, OWN_IP, 16'd5003, 16'd60000, 2);
    wait_replies();
endtask

task automatic test_port_miss();
    int stalls_before;
    stalls_before = rx_stall_cnt;
    send_frame(32'hC0A8_0108, OWN_IP, 16'd5004, 16'd1234, 5);
    // only the header handoff costs a cycle since dropped payload never waits
    check_value("rx_rdy stall cycles", rx_stall_cnt - stalls_before, 1);
    expect_quiet(20);
endtask

task automatic test_all_ports();
    int lens [6] = '{1, 5, 3, 7, 2, 4};
    for (int i = 0; i < 6; i++) begin
        send_frame(32'hAC10_0000 + i, OWN_IP, 16'(6000 + i), 16'(slot_ports[i % 3]), lens[i]);
    end
    wait_replies();
endtask

task automatic test_tx_backpressure();
    int lens [6] = '{6, 2, 9, 3, 5, 1};
    rdy_random = 1'b1;
    for (int i = 0; i < 6; i++) begin
        send_frame($random(seed), OWN_IP, 16'(7000 + i), 16'(slot_ports[(i + 1) % 3]), lens[i]);
    end
    wait_replies();
    rdy_random = 1'b0;
endtask

//--- dv/udp_echo_tb.sv
`timescale 1ns/100ps
module udp_echo_tb;
    import udp_echo_pkg::*;

    // words sent per test are 7, 6+5, 8, 18+22 and 18+26
    localparam int SENT_WORDS     = 7 + 11 + 8 + 40 + 44;
    localparam int TIMEOUT_CYCLES = SENT_WORDS * 8 + 200;
    localparam logic [31:0] OWN_IP = 32'h0A00_0001;

    logic               clk = 1'b0;
    logic               rst_n = 1'b0;
    logic               rx_val = 1'b0;
    logic [DATA_W-1:0]  rx_data = '0;
    logic               rx_last = 1'b0;
    logic               rx_rdy;
    logic               tx_val;
    logic [DATA_W-1:0]  tx_data;
    logic               tx_last;
    logic               tx_rdy = 1'b1;

    int unsigned        slot_ports [NUM_PORTS] = '{65432, 60000, 60001};
    logic [32:0]        exp_q [NUM_PORTS][$];   // {last, data} per slot
    logic [32:0]        cur [$];                // reply being collected
    int                 seed = 32'h9095;
    int                 rdy_seed = 32'h9095;
    logic               rdy_random = 1'b0;
    int                 errors = 0;
    int                 checks = 0;
    int                 cycle_cnt = 0;
    int                 rx_stall_cnt = 0;       // cycles a driven rx word waited
    logic               stall_q = 1'b0;
    logic [DATA_W-1:0]  data_q;
    logic               last_q;

    `include "udp_echo_tasks.svh"

    udp_echo_top udp_echo_top_inst (
         .clk (clk), .rst_n (rst_n)
        ,.rx_val (rx_val), .rx_data (rx_data), .rx_last (rx_last), .rx_rdy (rx_rdy)
        ,.tx_val (tx_val), .tx_data (tx_data), .tx_last (tx_last), .tx_rdy (tx_rdy)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        logic [31:0] r;
        #1;
        r = $random(rdy_seed);
        tx_rdy = rdy_random ? r[0] : 1'b1;
    end

    // tx monitor samples mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            stall_q = 1'b0;
        end else begin
            if (stall_q) begin
                check_value("tx_val", tx_val, 1'b1);
                check_value("tx_data", tx_data, data_q);
                check_value("tx_last", tx_last, last_q);
            end
            stall_q = tx_val & ~tx_rdy;
            data_q = tx_data;
            last_q = tx_last;
            if (tx_val && tx_rdy) begin
                cur.push_back({tx_last, tx_data});
                if (tx_last) take_reply();
            end
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles with %0d reply words outstanding",
                 cycle_cnt, pending_words());
        $display("Regression failed");
        $finish;
    end

    initial begin
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_idle_after_reset();
        test_single_echo();
        test_ip_filter();
        test_port_miss();
        test_all_ports();
        test_tx_backpressure();
        expect_quiet(10);
        if (cur.size() != 0) report_failure("partial reply left on tx at end of run");
        if (pending_words() != 0) report_failure("expected replies never arrived");
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+dv
verilog/udp_echo_pkg.sv
verilog/udp_rx_parser.sv
verilog/udp_port_splitter.sv
verilog/udp_echo_slot.sv
verilog/udp_tx_merger.sv
verilog/udp_tx_serializer.sv
verilog/udp_echo_top.sv
dv/udp_echo_tb.sv
